// ==== Bender.yml ====
package:
  name: npc_fleet

sources:
  - include_dirs:
      - .
    files:
      - npcPkg.sv
      - aiSequencer.sv
      - patternTable.sv
      - enemyTracker.sv
      - spritePriority.sv
      - npcFleet.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - npcFleetTb.sv

// ==== aiSequencer.sv ====
`include "npc_consts.svh"

module aiSequencer
  import npcPkg::*;
(
  input  logic Clk,
  input  logic rstN,
  input  logic frameStrobe,
  input  logic restart,
  output stepT step
);

  logic halfTick;  // High after an odd number of strobes

  always_ff @(posedge Clk or negedge rstN)
  begin
    if (!rstN)
    begin
      halfTick <= 1'b0;
      step     <= '0;
    end
    else if (restart)
    begin
      halfTick <= 1'b0;
      step     <= '0;
    end
    else if (frameStrobe)
    begin
      halfTick <= ~halfTick;
      if (halfTick)
      begin
        if (step == stepT'(`NPC_STEPS - 1))
          step <= '0;
        else
          step <= step + stepT'(1);
      end
    end
  end

endmodule

// ==== all.f ====
+incdir+.
npcPkg.sv
aiSequencer.sv
patternTable.sv
enemyTracker.sv
spritePriority.sv
npcFleet.sv
npcFleetTb.sv

// ==== enemyTracker.sv ====
`include "npc_consts.svh"

module enemyTracker
  import npcPkg::*;
(
  input  logic        Clk,
  input  logic        rstN,
  input  logic        frameStrobe,
  input  logic        restart,
  input  npcOriginT   origin,
  input  npcMotionT   motion,
  input  logic        collision,
  input  coordT       drawX,
  input  coordT       drawY,
  output logic        visible,
  output logic        alive,
  output spriteCoordT spriteCoord
);

  // Position kept as a displacement from the level origin
  coordT xOfs;
  coordT yOfs;
  boomT  boom;

  coordT posX;
  coordT posY;
  coordT relX;
  coordT relY;
  coordT xOffset;
  logic  inWindow;

  always_ff @(posedge Clk or negedge rstN)
  begin
    if (!rstN)
    begin
      xOfs  <= '0;
      yOfs  <= '0;
      alive <= 1'b1;
      boom  <= boomIdle;
    end
    else if (restart)
    begin
      xOfs  <= '0;
      yOfs  <= '0;
      alive <= 1'b1;
      boom  <= boomIdle;
    end
    else if (frameStrobe)
    begin
      case (boom)
        boomIdle:
        begin
          if (alive && collision)
          begin
            alive <= 1'b0;
            boom  <= boomOne;  // Freeze here
          end
          else if (alive)
          begin
            xOfs <= xOfs + coordT'(motion.dx);
            yOfs <= yOfs + coordT'(motion.dy);
          end
        end
        boomOne:   boom <= boomTwo;
        boomTwo:   boom <= boomThree;
        default:   boom <= boomIdle;
      endcase
    end
  end

  assign posX = origin.x + xOfs;
  assign posY = origin.y + yOfs;

  // Unsigned distance also covers windows that wrap past 1023
  assign relX     = drawX - posX;
  assign relY     = drawY - posY;
  assign inWindow = (relX <= coordT'(`SPRITE_W)) && (relY <= coordT'(`SPRITE_H));

  always_comb
  begin
    case (boom)
      boomOne:   xOffset = coordT'(`OFFSET_BOOM1);
      boomTwo:   xOffset = coordT'(`OFFSET_BOOM2);
      boomThree: xOffset = coordT'(`OFFSET_BOOM3);
      default:   xOffset = coordT'(`OFFSET_LIVE);
    endcase
  end

  always_comb
  begin
    visible     = 1'b0;
    spriteCoord = '0;
    if (inWindow)
    begin
      visible       = alive || (boom != boomIdle);
      spriteCoord.x = relX + xOffset;
      spriteCoord.y = relY;
    end
  end

endmodule

// ==== npcFleet.sv ====
`include "npc_consts.svh"

module npcFleet
  import npcPkg::*;
(
  input  logic                  Clk,
  input  logic                  rstN,
  input  logic                  frameStrobe,
  input  logic                  restart,
  input  levelT                 level,
  input  coordT                 drawX,
  input  coordT                 drawY,
  input  logic [`NPC_COUNT-1:0] collision,
  output logic [`NPC_COUNT-1:0] visible,
  output logic [`NPC_COUNT-1:0] alive,
  output spriteCoordT           spriteCoord
);

  levelT       levelQ;  // Level of the running game
  stepT        step;
  npcOriginT   origin [`NPC_COUNT];
  npcMotionT   motion [`NPC_COUNT];
  spriteCoordT trackCoord [`NPC_COUNT];

  always_ff @(posedge Clk or negedge rstN)
  begin
    if (!rstN)
      levelQ <= '0;
    else if (restart)
      levelQ <= level;
  end

  aiSequencer sequencer
  (
    .Clk         (Clk),
    .rstN        (rstN),
    .frameStrobe (frameStrobe),
    .restart     (restart),
    .step        (step)
  );

  patternTable table0
  (
    .level  (levelQ),
    .step   (step),
    .origin (origin),
    .motion (motion)
  );

  for (genvar i = 0; i < `NPC_COUNT; i++)
  begin : genEnemy
    enemyTracker tracker
    (
      .Clk         (Clk),
      .rstN        (rstN),
      .frameStrobe (frameStrobe),
      .restart     (restart),
      .origin      (origin[i]),
      .motion      (motion[i]),
      .collision   (collision[i]),
      .drawX       (drawX),
      .drawY       (drawY),
      .visible     (visible[i]),
      .alive       (alive[i]),
      .spriteCoord (trackCoord[i])
    );
  end

  spritePriority priorityPick
  (
    .visible     (visible),
    .coords      (trackCoord),
    .spriteCoord (spriteCoord)
  );

endmodule

// ==== npcFleetTb.sv ====
`include "npc_consts.svh"

module npcFleetTb
  import npcPkg::*;
();

  // Strobe, longest gap and two probes per enemy
  localparam int frameCycles = 5 + 2 * `NPC_COUNT;
  localparam int cycleLimit  = 2 * (3 + 5 * frameCycles + 60 * frameCycles + 10 * frameCycles);

  logic                  Clk;
  logic                  rstN;
  logic                  frameStrobe;
  logic                  restart;
  levelT                 level;
  coordT                 drawX;
  coordT                 drawY;
  logic [`NPC_COUNT-1:0] collision;
  logic [`NPC_COUNT-1:0] visible;
  logic [`NPC_COUNT-1:0] alive;
  spriteCoordT           spriteCoord;

  // Reference model of the fleet
  coordT                 mX [`NPC_COUNT];
  coordT                 mY [`NPC_COUNT];
  int                    mBoom [`NPC_COUNT];  // 0 idle, 1 to 3 explosion frames
  logic [`NPC_COUNT-1:0] mAlive;
  int                    mLevel;
  int                    mStep;
  logic                  mHalf;

  patternT l0X [`NPC_COUNT] = '{noMove, backForth, noMove, noMove, noMove,
                                backForth, noMove, circleY, backForth, circleX};
  patternT l0Y [`NPC_COUNT] = '{noMove, noMove, circleY, circleX, noMove,
                                noMove, noMove, circleX, noMove, circleY};
  patternT l1X [`NPC_COUNT] = '{leftward, leftward, leftward, backForth, noMove,
                                noMove, backForth, rightward, rightward, rightward};
  coordT   l1Y [`NPC_COUNT] = '{100, 140, 160, 210, 280, 280, 210, 180, 120, 80};
  coordT   l2Y [`NPC_COUNT] = '{400, 350, 300, 250, 200, 200, 250, 300, 350, 400};

  logic [31:0]           lfsrState;
  logic [`NPC_COUNT-1:0] hitMask;
  int                    hitIdx;
  int                    errors;
  int                    checks;
  int                    testErrors;
  int                    testNum;
  int                    cycles;
  int                    tries;
  coordT                 px;
  coordT                 py;

  npcFleet DUT (.*);

  initial
  begin
    Clk = 1'b0;
    forever #4 Clk = ~Clk;
  end

  initial
  begin
    cycles = 0;
    while (cycles < cycleLimit)
    begin
      @(posedge Clk);
      cycles++;
    end
    $display("Run stopped after %0d cycles without finishing", cycleLimit);
    $display("FAIL: see errors above");
    $finish;
  end

  // Restart refills the fleet a cycle later
  restartRefill: assert property (@(posedge Clk) disable iff (!rstN) restart |=> (alive == '1))
  else
  begin
    $display("FAIL alive after restart got %h expected %h", alive, {`NPC_COUNT{1'b1}});
    errors++;
  end

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic int takeBits(input int n);
    int v;
    v = 0;
    for (int b = 0; b < n; b++)
    begin
      v = (v << 1) | int'(lfsrState[0]);
      lfsrState = lfsrNext(lfsrState);  // One step per bit
    end
    return v;
  endfunction

  function automatic patternT patternFor(input int lvl, input int i, input logic vertical);
    if (vertical)
      return (lvl == 0) ? l0Y[i] : noMove;
    return (lvl == 0) ? l0X[i] : (lvl == 1) ? l1X[i] : backForth;
  endfunction

  function automatic int deltaOf(input patternT p, input int s);
    case (p)
      circleX:   return (s <= 4 || s >= 15) ? 1 : -1;
      circleY:   return (s <= 9) ? -1 : 1;
      backForth: return (s % 2 == 1) ? 2 : -2;
      leftward:  return -2;
      rightward: return 2;
      default:   return 0;
    endcase
  endfunction

  function automatic int sheetColumn(input int b);
    case (b)
      1:       return `OFFSET_BOOM1;
      2:       return `OFFSET_BOOM2;
      3:       return `OFFSET_BOOM3;
      default: return `OFFSET_LIVE;
    endcase
  endfunction

  // Window test with wrap at 1024
  function automatic logic inWindow(input int i, input coordT x, input coordT y);
    coordT rx;
    coordT ry;
    rx = x - mX[i];
    ry = y - mY[i];
    return (rx <= `SPRITE_W) && (ry <= `SPRITE_H);
  endfunction

  task automatic resetModel(input int lvl);
    mLevel = (lvl == 3) ? 0 : lvl;  // Level 3 plays as level 0
    mStep  = 0;
    mHalf  = 1'b0;
    mAlive = '1;
    for (int i = 0; i < `NPC_COUNT; i++)
    begin
      mX[i]    = (mLevel == 0) ? coordT'(560 - 60 * i) : coordT'(598 - 62 * i);
      mY[i]    = (mLevel == 0) ? coordT'(40) : (mLevel == 1) ? l1Y[i] : l2Y[i];
      mBoom[i] = 0;
    end
  endtask

  task automatic restartLevel(input int lvl);
    @(posedge Clk);
    restart <= 1'b1;
    level   <= levelT'(lvl);
    @(posedge Clk);
    restart <= 1'b0;
    resetModel(lvl);
  endtask

  task automatic applyFrame(input logic [`NPC_COUNT-1:0] coll);
    @(posedge Clk);
    frameStrobe <= 1'b1;
    collision   <= coll;
    @(posedge Clk);
    frameStrobe <= 1'b0;
    collision   <= '0;
    for (int i = 0; i < `NPC_COUNT; i++)
    begin
      if (mBoom[i] != 0)
        mBoom[i] = (mBoom[i] + 1) % 4;
      else if (mAlive[i] && coll[i])
      begin
        mAlive[i] = 1'b0;
        mBoom[i]  = 1;
      end
      else if (mAlive[i])
      begin
        mX[i] = coordT'(int'(mX[i]) + deltaOf(patternFor(mLevel, i, 1'b0), mStep));
        mY[i] = coordT'(int'(mY[i]) + deltaOf(patternFor(mLevel, i, 1'b1), mStep));
      end
    end
    if (mHalf)
      mStep = (mStep + 1) % `NPC_STEPS;
    mHalf = !mHalf;
  endtask

  task automatic expectHex(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic probeAt(input coordT x, input coordT y);
    logic [`NPC_COUNT-1:0] expVis;
    spriteCoordT           expCoord;
    @(posedge Clk);
    drawX <= x;
    drawY <= y;
    @(negedge Clk);
    expVis   = '0;
    expCoord = '0;
    for (int i = 0; i < `NPC_COUNT; i++)
    begin
      if (inWindow(i, x, y) && (mAlive[i] || mBoom[i] != 0))
      begin
        if (expVis == '0)
        begin
          expCoord.x = x - mX[i] + coordT'(sheetColumn(mBoom[i]));
          expCoord.y = y - mY[i];
        end
        expVis[i] = 1'b1;
      end
    end
    expectHex("visible", visible, expVis);
    expectHex("alive", alive, mAlive);
    expectHex("spriteCoord", spriteCoord, expCoord);
  endtask

  task automatic checkOrigins();
    for (int i = 0; i < `NPC_COUNT; i++)
    begin
      probeAt(mX[i], mY[i]);
      expectHex($sformatf("spriteCoord at origin %0d", i), spriteCoord,
                {coordT'(`OFFSET_LIVE), coordT'(0)});
      probeAt(mX[i] - 1'b1, mY[i]);
      expectHex($sformatf("visible[%0d] left of window", i), visible[i], 1'b0);
    end
  endtask

  task automatic finishTest(input string name);
    testNum++;
    $display("Test %0d %s: %s, %0d errors", testNum, name,
             (errors == testErrors) ? "ok" : "failed", errors - testErrors);
    testErrors = errors;
  endtask

  initial
  begin
    rstN        = 1'b0;
    frameStrobe = 1'b0;
    restart     = 1'b0;
    level       = '0;
    drawX       = '0;
    drawY       = '0;
    collision   = '0;
    lfsrState   = 32'hbd2b13a3;
    errors      = 0;
    checks      = 0;
    testErrors  = 0;
    testNum     = 0;
    repeat (3) @(posedge Clk);
    rstN <= 1'b1;
    resetModel(0);

    checkOrigins();
    for (int lvl = 0; lvl < 3; lvl++)
    begin
      restartLevel(lvl);
      checkOrigins();
    end
    finishTest("start positions");

    restartLevel(takeBits(2));
    for (int f = 0; f < 60; f++)
    begin
      applyFrame('0);
      repeat (takeBits(2)) @(posedge Clk);
      for (int i = 0; i < `NPC_COUNT; i++)
      begin
        probeAt(mX[i], mY[i]);
        probeAt(mX[i] + `SPRITE_W, mY[i] + `SPRITE_H);
        expectHex($sformatf("spriteCoord at corner %0d", i), spriteCoord,
                  {coordT'(`OFFSET_LIVE + `SPRITE_W), coordT'(`SPRITE_H)});
      end
    end
    finishTest("motion");

    hitIdx          = takeBits(4) % `NPC_COUNT;
    hitMask         = '0;
    hitMask[hitIdx] = 1'b1;
    applyFrame(hitMask);
    for (int f = 0; f < 6; f++)
    begin
      probeAt(mX[hitIdx], mY[hitIdx]);  // Frozen spot
      if (f < 3)
        expectHex("spriteCoord.x of explosion", spriteCoord.x,
                  (f == 0) ? `OFFSET_BOOM1 : (f == 1) ? `OFFSET_BOOM2 : `OFFSET_BOOM3);
      else
        expectHex($sformatf("visible[%0d] after explosion", hitIdx), visible[hitIdx], 1'b0);
      applyFrame('0);
    end
    finishTest("collision");

    applyFrame(hitMask);
    for (int i = 0; i < `NPC_COUNT; i++)
      probeAt(mX[i], mY[i]);
    finishTest("hit on dead enemy");

    // One enemy is down, so restart has to bring it back
    restartLevel(mLevel);
    checkOrigins();
    finishTest("restart after hit");

    tries = 0;
    do
    begin
      px = coordT'(takeBits(10));
      py = coordT'(takeBits(9));
      tries++;
      hitMask = '0;
      for (int i = 0; i < `NPC_COUNT; i++)
        hitMask[i] = inWindow(i, px, py);
    end
    while (hitMask != '0 && tries < 64);
    if (hitMask != '0)
    begin
      $display("No pixel outside all enemy windows was found");
      errors++;
    end
    else
    begin
      probeAt(px, py);
      expectHex("visible outside windows", visible, '0);
      expectHex("spriteCoord outside windows", spriteCoord, '0);
    end
    finishTest("empty pixel");

    $display("Tests %0d, checks %0d, errors %0d", testNum, checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== npcPkg.sv ====
package npcPkg;

  typedef logic [9:0]        coordT;  // Screen position, wraps at 1024
  typedef logic signed [9:0] deltaT;
  typedef logic [4:0]        stepT;
  typedef logic [1:0]        levelT;

  typedef enum logic [2:0]
  {
    noMove,
    circleX,
    circleY,
    backForth,
    leftward,
    rightward
  } patternT;

  // Explosion frames after a hit
  typedef enum logic [1:0]
  {
    boomIdle,
    boomOne,
    boomTwo,
    boomThree
  } boomT;

  // Pixel position inside the sprite sheet
  typedef struct packed
  {
    coordT x;
    coordT y;
  } spriteCoordT;

  typedef struct packed
  {
    deltaT dx;
    deltaT dy;
  } npcMotionT;

  typedef struct packed
  {
    coordT x;
    coordT y;
  } npcOriginT;

endpackage

// ==== npc_consts.svh ====
`ifndef NPC_CONSTS_SVH
`define NPC_CONSTS_SVH

// Fleet size and pattern length
`define NPC_COUNT 10
`define NPC_STEPS 20

// Visible screen area
`define SCREEN_W 640
`define SCREEN_H 480

// Inclusive sprite extents, window is 16x18 pixels
`define SPRITE_W 15
`define SPRITE_H 17

// Sprite sheet column of each frame
`define OFFSET_LIVE  69
`define OFFSET_BOOM1 50
`define OFFSET_BOOM2 25
`define OFFSET_BOOM3 1

// Motion magnitudes per step
`define SLOW_STEP 1
`define MID_STEP  2

`endif

// ==== patternTable.sv ====
`include "npc_consts.svh"

module patternTable
  import npcPkg::*;
(
  input  levelT     level,
  input  stepT      step,
  output npcOriginT origin [`NPC_COUNT],
  output npcMotionT motion [`NPC_COUNT]
);

  // Level 3 falls through to the level 0 layout
  function automatic npcOriginT originFor(input levelT lvl, input int idx);
    npcOriginT org;
    org.x = coordT'(560 - 60 * idx);
    org.y = coordT'(40);
    case (lvl)
      2'd1:
      begin
        org.x = coordT'(598 - 62 * idx);
        case (idx)
          0:       org.y = coordT'(100);
          1:       org.y = coordT'(140);
          2:       org.y = coordT'(160);
          3:       org.y = coordT'(210);
          4, 5:    org.y = coordT'(280);
          6:       org.y = coordT'(210);
          7:       org.y = coordT'(180);
          8:       org.y = coordT'(120);
          default: org.y = coordT'(80);
        endcase
      end
      2'd2:
      begin
        org.x = coordT'(598 - 62 * idx);
        case (idx)
          0, 9:    org.y = coordT'(400);
          1, 8:    org.y = coordT'(350);
          2, 7:    org.y = coordT'(300);
          3, 6:    org.y = coordT'(250);
          default: org.y = coordT'(200);
        endcase
      end
      default: ;
    endcase
    return org;
  endfunction

  function automatic patternT xPattern(input levelT lvl, input int idx);
    patternT pat;
    pat = noMove;
    case (lvl)
      2'd1:
      begin
        if (idx <= 2)
          pat = leftward;
        else if (idx == 3 || idx == 6)
          pat = backForth;
        else if (idx >= 7)
          pat = rightward;
      end
      2'd2: pat = backForth;  // Whole row sways together
      default:
      begin
        case (idx)
          1, 5, 8: pat = backForth;
          7:       pat = circleY;
          9:       pat = circleX;
          default: pat = noMove;
        endcase
      end
    endcase
    return pat;
  endfunction

  // Only level 0 moves vertically
  function automatic patternT yPattern(input levelT lvl, input int idx);
    patternT pat;
    pat = noMove;
    if (lvl == 2'd0 || lvl == 2'd3)
    begin
      case (idx)
        2, 9:    pat = circleY;
        3, 7:    pat = circleX;
        default: pat = noMove;
      endcase
    end
    return pat;
  endfunction

  function automatic deltaT deltaFor(input patternT pat, input stepT s);
    deltaT slow;
    deltaT mid;
    slow = deltaT'(`SLOW_STEP);
    mid  = deltaT'(`MID_STEP);
    case (pat)
      circleX:   return (s <= stepT'(4) || s >= stepT'(15)) ? slow : -slow;
      circleY:   return (s <= stepT'(9)) ? -slow : slow;
      backForth: return s[0] ? mid : -mid;
      leftward:  return -mid;
      rightward: return mid;
      default:   return '0;
    endcase
  endfunction

  always_comb
  begin
    for (int i = 0; i < `NPC_COUNT; i++)
    begin
      origin[i]    = originFor(level, i);
      motion[i].dx = deltaFor(xPattern(level, i), step);
      motion[i].dy = deltaFor(yPattern(level, i), step);
    end
  end

endmodule

// ==== spritePriority.sv ====
`include "npc_consts.svh"

module spritePriority
  import npcPkg::*;
(
  input  logic [`NPC_COUNT-1:0] visible,
  input  spriteCoordT           coords [`NPC_COUNT],
  output spriteCoordT           spriteCoord
);

  // Walk down so the lowest visible index is written last
  always_comb
  begin
    spriteCoord = '0;
    for (int i = `NPC_COUNT - 1; i >= 0; i--)
    begin
      if (visible[i])
        spriteCoord = coords[i];
    end
  end

endmodule
